/* song.mem */
// one note per line: freq in Hz in bits [13:4], beats in bits [3:0]; 13 intro then 29 chorus
14A2
14A2
14A4
0002
14A2
20B2
1884
1062
1262
14A4
15D1
14A1
126A
1882
1882
1B84
1882
20B2
1EE4
0001
1882
1882
1B84
1882
24B2
20B4
0003
1882
1882
2932
20B2
1EE2
1B82
15D3
15D1
20B2
1884
1B82
1EE2
20B3
0001
20B8

/* vlog.f */
+incdir+include
logic/song_pkg.sv
logic/player_pkg.sv
logic/song_rom.sv
logic/tone_gen.sv
logic/note_sequencer.sv
logic/seg7_decoder.sv
logic/music_top.sv
sim/music_tb.sv

/* Bender.yml */
package:
  name: music_player

export_include_dirs:
  - include

sources:
  - logic/song_pkg.sv
  - logic/player_pkg.sv
  - logic/song_rom.sv
  - logic/tone_gen.sv
  - logic/note_sequencer.sv
  - logic/seg7_decoder.sv
  - logic/music_top.sv
  - target: simulation
    files:
      - sim/music_tb.sv

/* sim/music_tb.sv */
/* tune player testbench
   random tempo and reset point, cycle-level model of sequencer and tone */
`default_nettype none
`timescale 1ns/1ps

`include "player_defines.svh"

module music_tb
  import song_pkg::*, player_pkg::*;
();

  localparam int BEAT_MS    = 4;
  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 8;

  logic        clk;
  logic        rst;
  logic [15:0] ticks_per_milli;
  wire         sound;
  wire         beat_led;
  wire  [6:0]  segments;

  note_t       song [0:`SONG_DEPTH-1]; // model copy of the note ROM
  logic [31:0] rng_state;
  int          tpm_a, tpm_b, run_a, loop_b, watchdog_cycles;
  int          mismatch_count, other_count, notes_checked;
  logic        checking, looped;
  seq_state_t  m_state;
  part_t       m_part;
  int          m_idx, m_remain;        // note in part, cycles left in state
  note_t       m_note;
  freq_t       m_freq;
  logic        m_led, m_snd;
  logic [31:0] m_acc;
  freq_t       dut_toggles, mdl_toggles; // per note
  logic        prev_sound, prev_m_snd, note_open;

  music_top #(
    .beat_ms (BEAT_MS)
  ) music_top_inst (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .sound           (sound),
    .beat_led        (beat_led),
    .segments        (segments)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic int part_base(input part_t p);
    return (p == PART_INTRO_A || p == PART_INTRO_B) ? `INTRO_BASE : `CHORUS_BASE;
  endfunction

  function automatic int part_len(input part_t p);
    return (p == PART_INTRO_A || p == PART_INTRO_B) ? `INTRO_LEN : `CHORUS_LEN;
  endfunction

  // one pass over all four parts, load + play + gap per note
  function automatic int loop_cycles(input int tpm);
    int total;
    int beats;
    total = 0;
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < part_len(part_t'(k)); i++) begin
        beats = int'(song[part_base(part_t'(k)) + i].beats);
        total += 1 + beats * BEAT_MS * tpm + (beats * BEAT_MS / 3) * tpm;
      end
    end
    return total;
  endfunction

  task automatic check_part(input part_t exp);
    logic [6:0] want;
    want = (exp == PART_INTRO_A) ? `SEG_DIGIT_1 : (exp == PART_INTRO_B) ? `SEG_DIGIT_2 :
           (exp == PART_CHORUS_A) ? `SEG_DIGIT_3 : `SEG_DIGIT_4;
    if (segments !== want) begin
      mismatch_count++;
      $display("mismatch segments: got 0x%0h, expected 0x%0h at %0t", segments, want, $time);
    end
  endtask

  task automatic check_led(input logic exp);
    if (beat_led !== exp) begin
      mismatch_count++;
      $display("mismatch beat_led: got 0x%0h, expected 0x%0h at %0t", beat_led, exp, $time);
    end
  endtask

  task automatic check_sound(input logic exp);
    if (sound !== exp) begin
      mismatch_count++;
      $display("mismatch sound: got 0x%0h, expected 0x%0h at %0t", sound, exp, $time);
    end
  endtask

  task automatic check_freq(input freq_t got, input freq_t exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch sound toggles: got 0x%0h, expected 0x%0h at %0t", got, exp, $time);
    end
  endtask

  task automatic model_reset();
    m_state  = ST_LOAD;
    m_part   = PART_INTRO_A;
    m_idx    = 0;
    m_remain = 0;
    m_note   = '0;
    m_freq   = '0;
    m_led    = 1'b0;
    m_acc    = '0;
    m_snd    = 1'b0;
  endtask

  task automatic advance_note();
    m_idx++;
    if (m_idx == part_len(m_part)) begin
      m_idx  = 0;
      looped = looped | (m_part == PART_CHORUS_B); // back to part 1
      m_part = (m_part == PART_CHORUS_B) ? PART_INTRO_A : part_t'(m_part + 1);
    end
  endtask

  // one clock edge of the model, with the inputs the DUT sees at that edge
  task automatic model_step();
    logic [31:0] half_rate;
    logic [31:0] phase;
    int          gap;
    half_rate = 32'(ticks_per_milli) * 32'(`HALF_RATE_MUL);
    phase     = m_acc + 32'(m_freq);
    if (!rst) begin
      model_reset();
    end else begin
      if (m_freq == '0) begin
        m_acc = '0;
        m_snd = 1'b0;
      end else begin
        m_acc = (phase >= half_rate) ? phase - half_rate : phase;
        m_snd = m_snd ^ (phase >= half_rate);
      end
      case (m_state)
        ST_LOAD: begin
          m_note   = song[part_base(m_part) + m_idx];
          m_freq   = m_note.freq;
          m_led    = 1'b1;
          m_remain = int'(m_note.beats) * BEAT_MS * int'(ticks_per_milli);
          m_state  = ST_PLAY;
        end
        ST_PLAY: begin
          if (m_remain > 1) begin
            m_remain--;
          end else begin
            gap    = (int'(m_note.beats) * BEAT_MS / 3) * int'(ticks_per_milli);
            m_freq = '0;
            m_led  = 1'b0;
            m_state  = (gap > 0) ? ST_GAP : ST_LOAD;
            m_remain = gap;
            if (gap == 0) advance_note();
          end
        end
        default: begin
          if (m_remain > 1) begin
            m_remain--;
          end else begin
            m_state = ST_LOAD;
            advance_note();
          end
        end
      endcase
    end
  endtask

  // outputs are compared at the falling edge, between DUT updates
  always @(negedge clk) begin
    if (checking === 1'b1) begin
      check_led(m_led);
      check_sound(m_snd);
      check_part(m_part);
      dut_toggles = dut_toggles + freq_t'(sound !== prev_sound);
      mdl_toggles = mdl_toggles + freq_t'(m_snd !== prev_m_snd);
      prev_sound  = sound;
      prev_m_snd  = m_snd;
      if (m_state == ST_LOAD) begin
        if (note_open && rst) begin
          check_freq(dut_toggles, mdl_toggles);
          notes_checked++;
        end
        note_open   = rst; // a note cut by reset is not compared
        dut_toggles = '0;
        mdl_toggles = '0;
      end
      model_step();
    end
  end

  task automatic apply_reset(input int tpm);
    @(posedge clk);
    rst             <= 1'b0;
    ticks_per_milli <= 16'(tpm);
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b1;
  endtask

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    other_count++;
    $display("timeout, the song did not loop back to part 1 in %0d cycles", watchdog_cycles);
    $display("mismatches %0d, other failures %0d, notes checked %0d",
             mismatch_count, other_count, notes_checked);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    rst             = 1'b0;
    ticks_per_milli = 16'd1;
    checking        = 1'b0;
    looped          = 1'b0;
    mismatch_count  = 0;
    other_count     = 0;
    notes_checked   = 0;
    dut_toggles     = '0;
    mdl_toggles     = '0;
    prev_sound      = 1'b0;
    prev_m_snd      = 1'b0;
    note_open       = 1'b0;
    model_reset();
    $readmemh("song.mem", song);
    if ($isunknown(song[0]) || $isunknown(song[`SONG_DEPTH-1])) begin
      other_count++;
      $display("song.mem could not be read, the model has no notes");
    end
    rng_state = xorshift(32'd95);
    tpm_a     = 1 + int'(rng_state % 32'd3);
    rng_state = xorshift(rng_state);
    tpm_b     = 1 + int'(rng_state % 32'd3);
    rng_state = xorshift(rng_state);
    run_a     = loop_cycles(tpm_a) / 2 + int'(rng_state % 32'(loop_cycles(tpm_a) / 2));
    loop_b    = loop_cycles(tpm_b);
    $display("ticks_per_milli %0d then %0d, mid-song reset after %0d cycles",
             tpm_a, tpm_b, run_a);
    watchdog_cycles = (2 * (RST_CYCLES + 1) + run_a + loop_b + 42) * 12 / 10;
    @(posedge clk);
    checking = 1'b1;
    apply_reset(tpm_a);
    repeat (run_a) @(posedge clk);
    looped = 1'b0;
    apply_reset(tpm_b); // restart mid-song with a new timebase
    wait (looped === 1'b1);
    repeat (40) @(posedge clk);
    checking = 1'b0;
    if (notes_checked == 0) begin
      other_count++;
      $display("no complete note was compared");
    end
    $display("mismatches %0d, other failures %0d, notes checked %0d",
             mismatch_count, other_count, notes_checked);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/music_top.sv */
/* tune player top
   note ROM, sequencer, tone generator and part display */
`default_nettype none
`timescale 1ns/1ps

`include "player_defines.svh"

module music_top
  import song_pkg::*, player_pkg::*;
#(
  parameter int beat_ms = `BEAT_MS_DEFAULT
) (
  input  wire         clk,
  input  wire         rst,
  input  wire  [15:0] ticks_per_milli,
  output wire         sound,
  output wire         beat_led,
  output wire  [6:0]  segments
);

  note_addr_t rom_addr;
  note_t      note;
  freq_t      tone_freq;
  part_t      part;

  song_rom song_rom_inst (
    .addr (rom_addr),
    .note (note)
  );

  note_sequencer #(
    .beat_ms (beat_ms)
  ) note_sequencer_inst (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .note            (note),
    .rom_addr        (rom_addr),
    .tone_freq       (tone_freq),
    .beat_led        (beat_led),
    .part            (part)
  );

  tone_gen tone_gen_inst (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .freq            (tone_freq),
    .sound           (sound)
  );

  seg7_decoder seg7_decoder_inst (
    .part     (part),
    .segments (segments)
  );

endmodule

`default_nettype wire

/* logic/seg7_decoder.sv */
/* seven-segment decoder
   shows the current song part as digit 1 to 4 */
`default_nettype none
`timescale 1ns/1ps

`include "player_defines.svh"

module seg7_decoder
  import player_pkg::*;
(
  input  part_t       part,
  output logic [6:0]  segments
);

  always_comb begin
    case (part)
      PART_INTRO_A:  segments = `SEG_DIGIT_1;
      PART_INTRO_B:  segments = `SEG_DIGIT_2;
      PART_CHORUS_A: segments = `SEG_DIGIT_3;
      PART_CHORUS_B: segments = `SEG_DIGIT_4;
      default:       segments = `SEG_BLANK; // unknown part
    endcase
  end

endmodule

`default_nettype wire

/* logic/note_sequencer.sv */
/* note sequencer
   ms timebase, play and gap timing per note, part stepping through the song */
`default_nettype none
`timescale 1ns/1ps

`include "player_defines.svh"

module note_sequencer
  import song_pkg::*, player_pkg::*;
#(
  parameter int beat_ms = `BEAT_MS_DEFAULT
) (
  input  wire               clk,
  input  wire               rst,
  input  wire        [15:0] ticks_per_milli,
  input  note_t             note,
  output note_addr_t        rom_addr,
  output freq_t             tone_freq,
  output logic              beat_led,
  output part_t             part
);

  seq_state_t  state;
  note_addr_t  idx;       // note within current part
  note_addr_t  part_base;
  note_addr_t  part_len;
  part_t       part_next;

  logic [15:0] tick_cnt;  // ms prescaler
  logic [15:0] ms_cnt;    // ms spent in current state
  logic [15:0] note_ms;   // play length
  logic [15:0] gap_ms;    // gap length, a third of play
  logic [15:0] load_ms;
  logic [15:0] target_ms;
  logic        ms_tick;
  logic        seg_done;  // play or gap time used up
  logic        note_end;  // move on to next note

  // part layout
  always_comb begin
    case (part)
      PART_INTRO_A,
      PART_INTRO_B: begin
        part_base = note_addr_t'(`INTRO_BASE);
        part_len  = note_addr_t'(`INTRO_LEN);
      end
      default: begin
        part_base = note_addr_t'(`CHORUS_BASE);
        part_len  = note_addr_t'(`CHORUS_LEN);
      end
    endcase
  end

  always_comb begin
    case (part)
      PART_INTRO_A:  part_next = PART_INTRO_B;
      PART_INTRO_B:  part_next = PART_CHORUS_A;
      PART_CHORUS_A: part_next = PART_CHORUS_B;
      default:       part_next = PART_INTRO_A; // loop the song
    endcase
  end

  assign rom_addr  = part_base + idx;
  assign load_ms   = 16'(note.beats * beat_ms);
  assign target_ms = (state == ST_GAP) ? gap_ms : note_ms;
  assign ms_tick   = (tick_cnt == ticks_per_milli - 16'd1);
  assign seg_done  = ms_tick && (ms_cnt + 16'd1 >= target_ms);

  // a zero-length gap goes straight back to load
  assign note_end = seg_done && ((state == ST_GAP) || (state == ST_PLAY && gap_ms == '0));

  // timebase restarts with every state so lengths are whole ms
  always_ff @(posedge clk) begin
    if (!rst) begin
      tick_cnt <= '0;
      ms_cnt   <= '0;
    end else if (state == ST_LOAD || seg_done) begin
      tick_cnt <= '0;
      ms_cnt   <= '0;
    end else if (ms_tick) begin
      tick_cnt <= '0;
      ms_cnt   <= ms_cnt + 16'd1;
    end else begin
      tick_cnt <= tick_cnt + 16'd1;
    end
  end

  // lengths latched once per note
  always_ff @(posedge clk) begin
    if (state == ST_LOAD) begin
      note_ms <= load_ms;
      gap_ms  <= load_ms / 16'd3;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state     <= ST_LOAD;
      tone_freq <= '0;
      beat_led  <= 1'b0;
    end else begin
      case (state)
        ST_LOAD: begin
          state     <= ST_PLAY;
          tone_freq <= note.freq; // rests play as freq 0
          beat_led  <= 1'b1;
        end
        ST_PLAY: begin
          if (seg_done) begin
            state     <= (gap_ms == '0) ? ST_LOAD : ST_GAP;
            tone_freq <= '0;
            beat_led  <= 1'b0;
          end
        end
        ST_GAP: begin
          if (seg_done) begin
            state <= ST_LOAD;
          end
        end
        default: state <= ST_LOAD;
      endcase
    end
  end

  // note index and part
  always_ff @(posedge clk) begin
    if (!rst) begin
      idx  <= '0;
      part <= PART_INTRO_A;
    end else if (note_end) begin
      if (idx == part_len - note_addr_t'(1)) begin
        idx  <= '0;
        part <= part_next;
      end else begin
        idx  <= idx + note_addr_t'(1);
      end
    end
  end

  a_led_in_play: assert property (
    @(posedge clk) disable iff (!rst) beat_led == (state == ST_PLAY)
  );

  // part base plus index never runs off the song
  a_addr_in_rom: assert property (
    @(posedge clk) disable iff (!rst) rom_addr < note_addr_t'(`SONG_DEPTH)
  );

  a_quiet_outside_play: assert property (
    @(posedge clk) disable iff (!rst) (state != ST_PLAY) |-> (tone_freq == '0)
  );

endmodule

`default_nettype wire

/* logic/tone_gen.sv */
/* square-wave tone generator
   phase accumulator toggles sound at twice the note frequency */
`default_nettype none
`timescale 1ns/1ps

`include "player_defines.svh"

module tone_gen
  import song_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  wire  [15:0] ticks_per_milli,
  input  freq_t       freq,
  output logic        sound
);

  logic [31:0] half_rate; // clock rate / 2
  logic [31:0] acc;
  logic [31:0] acc_sum;

  assign half_rate = 32'(ticks_per_milli) * 32'(`HALF_RATE_MUL);
  assign acc_sum   = acc + 32'(freq);

  always_ff @(posedge clk) begin
    if (!rst) begin
      acc   <= '0;
      sound <= 1'b0;
    end else if (freq == '0) begin
      acc   <= '0; // next note starts at phase zero
      sound <= 1'b0;
    end else if (acc_sum >= half_rate) begin
      acc   <= acc_sum - half_rate; // freq < half_rate, one step is enough
      sound <= ~sound;
    end else begin
      acc   <= acc_sum;
    end
  end

  // rest or gap silences the pin on the next edge
  a_silent_on_rest: assert property (
    @(posedge clk) disable iff (!rst) (freq == '0) |=> !sound
  );

endmodule

`default_nettype wire

/* logic/song_rom.sv */
/* song note ROM
   contents come from song.mem, asynchronous read */
`default_nettype none
`timescale 1ns/1ps

`include "player_defines.svh"

module song_rom (
  input  song_pkg::note_addr_t addr,
  output song_pkg::note_t      note
);

  song_pkg::note_t mem [0:`SONG_DEPTH-1]; // freq and beats per word

  initial begin
    $readmemh("song.mem", mem);
  end

  // addresses past the song read as a short rest
  always_comb begin
    if (addr < song_pkg::note_addr_t'(`SONG_DEPTH)) begin
      note = mem[addr];
    end else begin
      note = '0;
    end
  end

endmodule

`default_nettype wire

/* logic/player_pkg.sv */
/* player control types
   sequencer states and song parts */
`default_nettype none

package player_pkg;

  typedef enum logic [1:0] {
    ST_LOAD, // fetch next note
    ST_PLAY, // tone on, led on
    ST_GAP   // silence between notes
  } seq_state_t;

  // four parts, looped
  typedef enum logic [1:0] {
    PART_INTRO_A  = 2'd0,
    PART_INTRO_B  = 2'd1,
    PART_CHORUS_A = 2'd2,
    PART_CHORUS_B = 2'd3
  } part_t;

endpackage

`default_nettype wire

/* logic/song_pkg.sv */
/* song data types
   layout of one stored note and of the note ROM address */
`default_nettype none

package song_pkg;

  // tone frequency in Hz, zero is a rest
  typedef logic [9:0] freq_t;

  // note length in beats, 1 to 10
  typedef logic [3:0] beats_t;

  // one song.mem word, freq in [13:4], beats in [3:0]
  typedef struct packed {
    freq_t  freq;
    beats_t beats;
  } note_t;

  // note ROM address
  typedef logic [5:0] note_addr_t;

endpackage

`default_nettype wire

/* include/player_defines.svh */
/* tune player constants
   tempo, song layout in the note ROM, tone divider and seven-segment patterns */
`ifndef PLAYER_DEFINES_SVH
`define PLAYER_DEFINES_SVH

// one beat in ms
`define BEAT_MS_DEFAULT 100

// note ROM layout
`define SONG_DEPTH  42
`define INTRO_BASE  0
`define INTRO_LEN   13
`define CHORUS_BASE 13
`define CHORUS_LEN  29

// half rate = ticks_per_milli * 500, i.e. half the clock rate in Hz
`define HALF_RATE_MUL 500

// active high, bit 0 is the top segment
`define SEG_DIGIT_1 7'b0000110
`define SEG_DIGIT_2 7'b1011011
`define SEG_DIGIT_3 7'b1001111
`define SEG_DIGIT_4 7'b1100110
`define SEG_BLANK   7'b0000000

`endif
